// File: design/conv_pkg.sv
package conv_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Activation/kernel window pairs per item
  localparam int CHANNELS = 4;
  localparam int TAPS = 25;

  localparam int PIXEL_W = 4;
  // 15 * 15 = 225
  localparam int PRODUCT_W = 8;
  // 25 * 225 = 5625
  localparam int PARTIAL_W = 13;
  // 4 * 5625 = 22500
  localparam int SUM_W = 15;

  // Adder tree leaves with the taps padded to a power of two
  localparam int TREE_LEAVES = 32;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [PIXEL_W-1:0] pixel_t;

  // Tap 0 in the most significant nibble
  typedef pixel_t [0:TAPS-1] window_t;

  // Channel 0 in the most significant window
  typedef window_t [0:CHANNELS-1] channel_windows_t;

  typedef logic [PARTIAL_W-1:0] partial_t;
  typedef partial_t [0:CHANNELS-1] partials_t;

  typedef logic [SUM_W-1:0] sum_t;

endpackage

// File: design/conv_partial_if.sv
`timescale 1ns/10ps

interface conv_partial_if;

  //////////////////////////////////////////////////
  // Per-channel partial sums with valid/ready
  //////////////////////////////////////////////////

  logic valid;
  logic ready;

  // One partial sum per channel, channel 0 first
  conv_pkg::partials_t partials;

  // MAC array side
  modport source (
    output valid,
    output partials,
    input  ready
  );

  // Result stage side
  modport sink (
    input  valid,
    input  partials,
    output ready
  );

endinterface

// File: design/conv_mac_array.sv
`timescale 1ns/10ps

module conv_mac_array (
  input  logic                        clk,
  input  logic                        rst,

  // Input item handshake
  input  logic                        in_valid,
  output logic                        in_ready,
  input  conv_pkg::channel_windows_t  act,
  input  conv_pkg::channel_windows_t  kernel,

  // Partial sums towards the result stage
  conv_partial_if.source              part
);

  // Combinational partial sums of the item on the input
  conv_pkg::partials_t sums;

  // First pipeline register
  conv_pkg::partials_t partials_q;
  logic                valid_q;

  logic                accept;

  //////////////////////////////////////////////////
  // Multipliers and adder trees
  //////////////////////////////////////////////////

  for (genvar c = 0; c < conv_pkg::CHANNELS; c++) begin : g_chan

    // Heap layout with node 0 at the root
    conv_pkg::partial_t node [2*conv_pkg::TREE_LEAVES-1];

    for (genvar k = 0; k < conv_pkg::TREE_LEAVES; k++) begin : g_leaf
      if (k < conv_pkg::TAPS) begin : g_tap
        logic [conv_pkg::PRODUCT_W-1:0] prod;

        assign prod = act[c][k] * kernel[c][k];
        assign node[conv_pkg::TREE_LEAVES-1+k] = conv_pkg::partial_t'(prod);
      end else begin : g_pad
        // Unused leaves of the padded tree
        assign node[conv_pkg::TREE_LEAVES-1+k] = '0;
      end
    end

    // Each inner node adds its two children
    for (genvar n = 0; n < conv_pkg::TREE_LEAVES-1; n++) begin : g_node
      assign node[n] = node[2*n+1] + node[2*n+2];
    end

    assign sums[c] = node[0];
  end

  //////////////////////////////////////////////////
  // Handshake and pipeline register
  //////////////////////////////////////////////////

  // Free slot, or the held item leaves this cycle
  assign in_ready = part.ready | ~valid_q;
  assign accept   = in_valid & in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (part.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      partials_q <= sums;
    end
  end

  assign part.valid    = valid_q;
  assign part.partials = partials_q;

endmodule

// File: design/conv_result.sv
`timescale 1ns/10ps

module conv_result (
  input  logic                clk,
  input  logic                rst,

  // Partial sums from the MAC array
  conv_partial_if.sink        part,

  // Result handshake
  output logic                out_valid,
  input  logic                out_ready,
  output conv_pkg::sum_t      conv_sum
);

  // Cross-channel total, full width
  conv_pkg::sum_t total;

  logic           load;

  //////////////////////////////////////////////////
  // Channel adder
  //////////////////////////////////////////////////

  always_comb begin
    total = '0;
    for (int c = 0; c < conv_pkg::CHANNELS; c++) begin
      total = total + conv_pkg::sum_t'(part.partials[c]);
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  // Result slot is free or drains this cycle
  assign part.ready = out_ready | ~out_valid;
  assign load       = part.valid & part.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Held stable while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      conv_sum <= total;
    end
  end

endmodule

// File: design/conv_stage.sv
`timescale 1ns/10ps

module conv_stage (
  input  logic                        clk,
  input  logic                        rst,

  // Input items
  input  logic                        in_valid,
  output logic                        in_ready,
  input  conv_pkg::channel_windows_t  act,
  input  conv_pkg::channel_windows_t  kernel,

  // Results
  output logic                        out_valid,
  input  logic                        out_ready,
  output conv_pkg::sum_t              conv_sum
);

  //////////////////////////////////////////////////
  // Array to result stage link
  //////////////////////////////////////////////////

  conv_partial_if part_if ();

  //////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////

  // Products and per-channel sums
  conv_mac_array conv_mac_array_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .act      (act),
    .kernel   (kernel),
    .part     (part_if.source)
  );

  // Channel total and output handshake
  conv_result conv_result_i (
    .clk       (clk),
    .rst       (rst),
    .part      (part_if.sink),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .conv_sum  (conv_sum)
  );

endmodule

// File: tests/conv_stage_tests.svh
`ifndef CONV_STAGE_TESTS_SVH
`define CONV_STAGE_TESTS_SVH

//////////////////////////////////////////////////
// Stimulus and checking helpers
//////////////////////////////////////////////////

// Same tap value everywhere
function automatic conv_pkg::channel_windows_t fill_windows(input conv_pkg::pixel_t value);
  conv_pkg::channel_windows_t w;
  for (int c = 0; c < conv_pkg::CHANNELS; c++) begin
    for (int t = 0; t < conv_pkg::TAPS; t++) begin
      w[c][t] = value;
    end
  end
  return w;
endfunction

function automatic conv_pkg::channel_windows_t random_windows();
  conv_pkg::channel_windows_t w;
  for (int c = 0; c < conv_pkg::CHANNELS; c++) begin
    for (int t = 0; t < conv_pkg::TAPS; t++) begin
      w[c][t] = conv_pkg::pixel_t'($urandom);
    end
  end
  return w;
endfunction

task automatic clear_log();
  expected.delete();
  results.delete();
  in_cycles.delete();
  out_cycles.delete();
endtask

// Four-state compare, so an unknown output never matches
task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] got);
  assert (got === exp) else begin
    $display("FAILED %s: expected %0d, actual %0d", name, exp, got);
    errors++;
  end
endtask

// Holds the item on the input until it is taken
task automatic push_item(input string name, input conv_pkg::channel_windows_t a,
                         input conv_pkg::channel_windows_t k);
  int waited;
  waited = 0;
  @(negedge clk);
  in_valid = 1'b1;
  act      = a;
  kernel   = k;
  #1;
  while (!in_ready && waited < TIMEOUT) begin
    @(negedge clk);
    #1;
    waited++;
  end
  assert (in_ready) else begin
    $display("%s: item not accepted, in_ready stayed low for %0d cycles", name, TIMEOUT);
    errors++;
  end
  @(posedge clk);
endtask

task automatic release_input();
  @(negedge clk);
  in_valid = 1'b0;
endtask

task automatic wait_results(input string name, input int count);
  int waited;
  waited = 0;
  while (results.size() < count && waited < TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  assert (results.size() >= count) else begin
    $display("%s: only %0d of %0d results arrived in time", name, results.size(), count);
    errors++;
  end
endtask

// Results in order against the values logged at input
task automatic compare_results(input string name);
  check_value({name, " result count"}, expected.size(), results.size());
  for (int i = 0; i < results.size() && i < expected.size(); i++) begin
    check_value($sformatf("%s item %0d", name, i), expected[i], results[i]);
  end
endtask

task automatic report_test(input string name, input int start);
  if (errors == start) begin
    passed++;
    $display("%s: done, no errors", name);
  end else begin
    failed++;
    $display("%s: done, %0d errors", name, errors - start);
  end
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic check_reset_state();
  int start;
  start = errors;
  @(negedge clk);
  check_value("reset_state out_valid", 0, out_valid);
  check_value("reset_state in_ready", 1, in_ready);
  report_test("reset_state", start);
endtask

task automatic run_extremes();
  int start;
  start = errors;
  clear_log();
  push_item("extremes", fill_windows(0), fill_windows(0));
  push_item("extremes", fill_windows(15), fill_windows(15));
  push_item("extremes", fill_windows(15), fill_windows(1));
  release_input();
  wait_results("extremes", 3);
  if (results.size() >= 3) begin
    check_value("extremes all zero", 0, results[0]);
    check_value("extremes all 15", 22500, results[1]);
    check_value("extremes kernel of ones", 1500, results[2]);
  end
  report_test("extremes", start);
endtask

task automatic run_random_items();
  conv_pkg::channel_windows_t a;
  conv_pkg::channel_windows_t k;
  int start;
  start = errors;
  clear_log();
  // One live channel per item, so every channel must reach the total
  for (int c = 0; c < conv_pkg::CHANNELS; c++) begin
    a    = fill_windows(15);
    k    = fill_windows(0);
    k[c] = a[c];
    push_item("random_items", a, k);
  end
  for (int i = 0; i < 50; i++) begin
    push_item("random_items", random_windows(), random_windows());
  end
  release_input();
  wait_results("random_items", 54);
  compare_results("random_items");
  report_test("random_items", start);
endtask

task automatic measure_latency();
  int start;
  start = errors;
  clear_log();
  push_item("latency", random_windows(), random_windows());
  release_input();
  wait_results("latency", 1);
  if (in_cycles.size() >= 1 && out_cycles.size() >= 1) begin
    check_value("latency cycles", 2, out_cycles[0] - in_cycles[0]);
  end
  clear_log();
  for (int i = 0; i < 10; i++) begin
    push_item("throughput", random_windows(), random_windows());
  end
  release_input();
  wait_results("throughput", 10);
  compare_results("throughput");
  for (int i = 1; i < out_cycles.size(); i++) begin
    check_value("throughput result gap", 1, out_cycles[i] - out_cycles[i-1]);
  end
  report_test("latency_throughput", start);
endtask

task automatic apply_back_pressure();
  conv_pkg::sum_t held;
  int start;
  start = errors;
  clear_log();
  @(negedge clk);
  out_ready = 1'b0;
  fork
    begin
      for (int i = 0; i < 5; i++) begin
        push_item("back_pressure", random_windows(), random_windows());
      end
      release_input();
    end
    begin
      // Both stages full after a few cycles
      repeat (4) @(negedge clk);
      held = conv_sum;
      check_value("back_pressure out_valid", 1, out_valid);
      repeat (6) begin
        @(negedge clk);
        check_value("back_pressure held sum", held, conv_sum);
      end
      check_value("back_pressure accepted items", 2, in_cycles.size());
      check_value("back_pressure in_ready", 0, in_ready);
      out_ready = 1'b1;
    end
  join
  wait_results("back_pressure", 5);
  compare_results("back_pressure");
  report_test("back_pressure", start);
endtask

`endif

// File: tests/conv_stage_tb.sv
`timescale 1ns/10ps

module conv_stage_tb;

  // Cycles any single wait may take
  localparam int TIMEOUT = 50;

  logic                       clk;
  logic                       rst;
  logic                       in_valid;
  logic                       in_ready;
  conv_pkg::channel_windows_t act;
  conv_pkg::channel_windows_t kernel;
  logic                       out_valid;
  logic                       out_ready;
  conv_pkg::sum_t             conv_sum;

  // Transfers seen on both handshakes
  conv_pkg::sum_t expected [$];
  conv_pkg::sum_t results [$];
  int             in_cycles [$];
  int             out_cycles [$];
  int             cycle;

  int errors;
  int passed;
  int failed;

  conv_stage conv_stage_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .act       (act),
    .kernel    (kernel),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .conv_sum  (conv_sum)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Sum over all channels and taps of activation times kernel
  function automatic conv_pkg::sum_t conv_ref(input conv_pkg::channel_windows_t a,
                                              input conv_pkg::channel_windows_t k);
    int total;
    total = 0;
    for (int c = 0; c < conv_pkg::CHANNELS; c++) begin
      for (int t = 0; t < conv_pkg::TAPS; t++) begin
        total += int'(a[c][t]) * int'(k[c][t]);
      end
    end
    return conv_pkg::sum_t'(total);
  endfunction

  //////////////////////////////////////////////////
  // Handshake monitor
  //////////////////////////////////////////////////

  // Inputs change on the falling edge, so values here are settled
  always @(posedge clk) begin
    if (!rst && in_valid && in_ready) begin
      expected.push_back(conv_ref(act, kernel));
      in_cycles.push_back(cycle);
    end
    if (!rst && out_valid && out_ready) begin
      results.push_back(conv_sum);
      out_cycles.push_back(cycle);
    end
    cycle++;
  end

  `include "conv_stage_tests.svh"

  initial begin
    void'($urandom(32'hca1c_4620));
    errors    = 0;
    passed    = 0;
    failed    = 0;
    cycle     = 0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    act       = '0;
    kernel    = '0;
    out_ready = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_reset_state();
    run_extremes();
    run_random_items();
    measure_latency();
    apply_back_pressure();

    $display("Tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+tests
design/conv_pkg.sv
design/conv_partial_if.sv
design/conv_mac_array.sv
design/conv_result.sv
design/conv_stage.sv
tests/conv_stage_tb.sv

// File: Makefile
# Verilator flow for the convolution stage

VERILATOR  := verilator
TOP        := conv_stage_tb
RTL_TOP    := conv_stage
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

# Lint the design from its top level
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Build, run, then pass only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
